// ==== fec_dma.f ====
common/fec_dma_pkg.sv
hw/csr_apb.sv
requestor/line_fifo.sv
requestor/line_reader.sv
requestor/byte_serializer.sv
requestor/line_writer.sv
hw/mem_arbiter.sv
hw/fec_dma_top.sv
sim/mem_model.sv
sim/fec_dma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module fec_dma_tb -f fec_dma.f \
  -o fec_dma_sim > build.log 2>&1 &&
./obj_dir/fec_dma_sim > sim.log 2>&1 ;
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== sim/fec_dma_tb.sv ====
// Testbench top with the job table, decoder stand-in, bus monitors, checks and timeout.
`timescale 1ns/100ps
`default_nettype none

module fec_dma_tb import fec_dma_pkg::*; ();

  localparam int fifo_lines = 8;
  localparam int byte_gap   = 3;
  localparam int num_jobs   = 3;

  typedef struct packed {
    addr_t       src_base;
    logic [15:0] lines;
    addr_t       dst_base;
    addr_t       dsm_addr;
    logic [31:0] ready_pct;
  } job_t;

  // The second job runs with long stretches of low ready.
  localparam job_t jobs [num_jobs] = '{
    '{32'h010, 16'd12, 32'h100, 32'h3F0, 32'd90},
    '{32'h040, 16'd20, 32'h180, 32'h3F1, 32'd25},
    '{32'h080, 16'd5,  32'h200, 32'h3F2, 32'd60}
  };

  logic        clk = 1'b0;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        mem_req_valid;
  logic        mem_req_ready;
  logic        mem_req_write;
  addr_t       mem_req_addr;
  line_t       mem_req_data;
  logic        mem_rsp_valid;
  logic        mem_rsp_write;
  line_t       mem_rsp_data;
  logic [7:0]  dec_in_data;
  logic        dec_in_valid;
  logic [7:0]  dec_out_data;
  logic        dec_out_valid;
  logic [31:0] ready_pct;
  int unsigned cycle = 0;
  int unsigned timeout_cycles = 0;
  int unsigned reads_issued = 0;
  int unsigned lines_popped = 0;
  int unsigned acks_seen = 0;
  int unsigned dec_bytes = 0;
  int unsigned last_byte_cycle = 0;
  logic        byte_seen = 1'b0;

  always #10 clk = ~clk;

  fec_dma_top #(
    .fifo_lines (fifo_lines),
    .byte_gap   (byte_gap)
  ) fec_dma_top_i (
    .clk           (clk),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_write (mem_rsp_write),
    .mem_rsp_data  (mem_rsp_data),
    .dec_in_data   (dec_in_data),
    .dec_in_valid  (dec_in_valid),
    .dec_out_data  (dec_out_data),
    .dec_out_valid (dec_out_valid)
  );

  mem_model mem_model_i (
    .clk       (clk),
    .reset     (reset),
    .ready_pct (ready_pct),
    .req_valid (mem_req_valid),
    .req_ready (mem_req_ready),
    .req_write (mem_req_write),
    .req_addr  (mem_req_addr),
    .req_data  (mem_req_data),
    .rsp_valid (mem_rsp_valid),
    .rsp_write (mem_rsp_write),
    .rsp_data  (mem_rsp_data)
  );

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "Stopping at the first error.");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  function automatic int unsigned run_cycle_limit();
    int unsigned total;
    total = 0;
    for (int j = 0; j < num_jobs; j++) begin
      total += int'(jobs[j].lines) * 8 * (byte_gap + 1 + 4) + 200;
    end
    return total;
  endfunction

  // Callers start at 2 ns after a rising edge and return at the same point.
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    check_value("apb write pready", 64'd1, 64'(pready));  // No wait states.
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    check_value("apb read pready", 64'd1, 64'(pready));
    data = prdata;  // Sampled mid access phase.
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (timeout_cycles != 0 && cycle >= timeout_cycles) begin
      $display("ERROR: timeout after %0d cycles, the job never reported done.", cycle);
      abort_run();
    end
  end

  // Bus monitors, sampled where every signal of the cycle is stable.
  always @(negedge clk) begin
    if (!reset) begin
      if (mem_req_valid && mem_req_ready) begin
        if (mem_req_write && fec_dma_top_i.done) begin
          $display("ERROR: memory write to %h issued after done.", mem_req_addr);
          abort_run();
        end
        if (!mem_req_write) reads_issued++;
      end
      if (fec_dma_top_i.line_pop) lines_popped++;
      if (reads_issued - lines_popped > fifo_lines) begin
        $display("ERROR: %0d reads outstanding beyond consumed lines.",
                 reads_issued - lines_popped);
        abort_run();
      end
      if (mem_rsp_valid && mem_rsp_write) acks_seen++;
      if (dec_in_valid) begin
        if (byte_seen && (cycle - last_byte_cycle < byte_gap + 1)) begin
          $display("ERROR: decoder bytes only %0d cycles apart.", cycle - last_byte_cycle);
          abort_run();
        end
        byte_seen = 1'b1;
        last_byte_cycle = cycle;
        dec_bytes++;
      end
    end
  end

  // Decoder stand-in returns each byte XOR 0x5A after 1 to 4 cycles, in order.
  initial begin
    int unsigned due_q [$];
    logic [7:0]  byte_q [$];
    int unsigned due;
    int unsigned last_due;
    last_due = 0;
    dec_out_valid = 1'b0;
    dec_out_data  = '0;
    forever begin
      @(negedge clk);
      if (!reset && dec_in_valid) begin
        due = cycle + 1 + ($urandom % 4);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        due_q.push_back(due);
        byte_q.push_back(dec_in_data ^ 8'h5A);
      end
      @(posedge clk);
      #2;
      dec_out_valid = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        void'(due_q.pop_front());
        dec_out_data  = byte_q.pop_front();
        dec_out_valid = 1'b1;
      end
    end
  end

  initial begin
    logic [31:0] rd;
    int unsigned acks_start;
    int unsigned bytes_start;
    logic [9:0]  idx;
    line_t       expected;
    void'($urandom(46305));
    reset     = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    ready_pct = 32'd100;
    timeout_cycles = run_cycle_limit();
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int j = 0; j < num_jobs; j++) begin
      apb_write(reg_src_base, jobs[j].src_base);
      apb_write(reg_src_lines, {16'b0, jobs[j].lines});
      apb_write(reg_dst_base, jobs[j].dst_base);
      apb_write(reg_dst_lines, {16'b0, jobs[j].lines});
      apb_write(reg_dsm_addr, jobs[j].dsm_addr);
      apb_read(reg_src_base, rd);
      check_value($sformatf("job %0d src_base", j), 64'(jobs[j].src_base), 64'(rd));
      apb_read(reg_src_lines, rd);
      check_value($sformatf("job %0d src_lines", j), 64'(jobs[j].lines), 64'(rd));
      apb_read(reg_dst_base, rd);
      check_value($sformatf("job %0d dst_base", j), 64'(jobs[j].dst_base), 64'(rd));
      apb_read(reg_dst_lines, rd);
      check_value($sformatf("job %0d dst_lines", j), 64'(jobs[j].lines), 64'(rd));
      apb_read(reg_dsm_addr, rd);
      check_value($sformatf("job %0d dsm_addr", j), 64'(jobs[j].dsm_addr), 64'(rd));
      apb_read(reg_status, rd);
      check_value($sformatf("job %0d status before start", j), (j == 0) ? 64'd0 : 64'd1,
                  64'(rd));
      ready_pct   = jobs[j].ready_pct;
      acks_start  = acks_seen;
      bytes_start = dec_bytes;
      apb_write(reg_ctrl, 32'd1);
      apb_read(reg_status, rd);
      check_value($sformatf("job %0d status after start", j), 64'd0, 64'(rd));
      rd = '0;
      while (rd[0] == 1'b0) apb_read(reg_status, rd);
      // All line writes and the completion write are acknowledged by now.
      check_value($sformatf("job %0d acks at done", j), 64'(int'(jobs[j].lines) + 1),
                  64'(acks_seen - acks_start));
      repeat (20) @(posedge clk);
      #2;
      check_value($sformatf("job %0d decoder bytes", j), 64'(int'(jobs[j].lines) * 8),
                  64'(dec_bytes - bytes_start));
      for (int k = 0; k < int'(jobs[j].lines); k++) begin
        idx = 10'(jobs[j].src_base + 32'(k));
        expected = mem_model_i.mem[idx] ^ {8{8'h5A}};  // Each byte XOR 0x5A.
        idx = 10'(jobs[j].dst_base + 32'(k));
        check_value($sformatf("job %0d dst line %0d", j, k), expected, mem_model_i.mem[idx]);
      end
      idx = jobs[j].dsm_addr[9:0];
      check_value($sformatf("job %0d completion flag", j), dsm_done_value,
                  mem_model_i.mem[idx]);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/mem_model.sv ====
// Memory model with random request ready and in-order responses after a random latency.
`timescale 1ns/100ps
`default_nettype none

module mem_model (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] ready_pct,
  input  logic        req_valid,
  output logic        req_ready,
  input  logic        req_write,
  input  logic [31:0] req_addr,
  input  logic [63:0] req_data,
  output logic        rsp_valid,
  output logic        rsp_write,
  output logic [63:0] rsp_data
);

  logic [63:0] mem [1024];
  int unsigned due_q [$];
  logic        write_q [$];
  logic [63:0] data_q [$];

  initial begin
    int unsigned cycle;
    int unsigned due;
    int unsigned last_due;
    int unsigned run_left;
    logic [31:0] a;
    cycle = 0;
    last_due = 0;
    run_left = 0;
    for (int i = 0; i < 1024; i++) begin
      a = i;
      mem[i] = {~a, a * 32'h9E37_79B1};  // Every address bit shows in the line.
    end
    req_ready = 1'b0;
    rsp_valid = 1'b0;
    rsp_write = 1'b0;
    rsp_data  = '0;
    forever begin
      @(negedge clk);
      if (!reset && req_valid && req_ready) begin
        due = cycle + 1 + ($urandom % 4);
        if (due <= last_due) due = last_due + 1;  // Responses stay in request order.
        last_due = due;
        due_q.push_back(due);
        write_q.push_back(req_write);
        if (req_write) begin
          mem[req_addr[9:0]] = req_data;
          data_q.push_back('0);
        end else begin
          data_q.push_back(mem[req_addr[9:0]]);
        end
      end
      @(posedge clk);
      #2;
      cycle++;
      rsp_valid = 1'b0;
      rsp_write = 1'b0;
      if (reset) begin
        req_ready = 1'b0;
        run_left  = 0;
      end else begin
        if (run_left == 0) begin
          req_ready = (($urandom % 100) < ready_pct);
          run_left  = 1 + ($urandom % 8);  // Ready holds for a random stretch.
        end
        run_left--;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
          void'(due_q.pop_front());
          rsp_valid = 1'b1;
          rsp_write = write_q.pop_front();
          rsp_data  = data_q.pop_front();
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/fec_dma_top.sv ====
// FEC DMA top level with register file, line reader, byte serializer, line writer and arbiter.
`timescale 1ns/100ps
`default_nettype none

module fec_dma_top import fec_dma_pkg::*; #(
  parameter int fifo_lines = 8,
  parameter int byte_gap   = 3
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        mem_req_valid,
  input  logic        mem_req_ready,
  output logic        mem_req_write,
  output addr_t       mem_req_addr,
  output line_t       mem_req_data,
  input  logic        mem_rsp_valid,
  input  logic        mem_rsp_write,
  input  line_t       mem_rsp_data,
  output logic [7:0]  dec_in_data,
  output logic        dec_in_valid,
  input  logic [7:0]  dec_out_data,
  input  logic        dec_out_valid
);

  logic        start;
  logic        done;
  addr_t       src_base;
  logic [15:0] src_lines;
  addr_t       dst_base;
  logic [15:0] dst_lines;
  addr_t       dsm_addr;
  logic        rd_valid;
  logic        rd_ready;
  addr_t       rd_addr;
  logic        rd_rsp_valid;
  line_t       rd_rsp_data;
  line_t       line_data;
  logic        line_valid;
  logic        line_pop;
  logic        wr_valid;
  logic        wr_ready;
  addr_t       wr_addr;
  line_t       wr_data;
  logic        wr_ack_valid;

  csr_apb csr_apb_i (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .start     (start),
    .src_base  (src_base),
    .src_lines (src_lines),
    .dst_base  (dst_base),
    .dst_lines (dst_lines),
    .dsm_addr  (dsm_addr),
    .done      (done)
  );

  line_reader #(
    .fifo_lines (fifo_lines)
  ) line_reader_i (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .src_base   (src_base),
    .src_lines  (src_lines),
    .rd_valid   (rd_valid),
    .rd_ready   (rd_ready),
    .rd_addr    (rd_addr),
    .rsp_valid  (rd_rsp_valid),
    .rsp_data   (rd_rsp_data),
    .line_data  (line_data),
    .line_valid (line_valid),
    .line_pop   (line_pop)
  );

  byte_serializer #(
    .byte_gap (byte_gap)
  ) byte_serializer_i (
    .clk          (clk),
    .reset        (reset),
    .line_data    (line_data),
    .line_valid   (line_valid),
    .line_pop     (line_pop),
    .dec_in_data  (dec_in_data),
    .dec_in_valid (dec_in_valid)
  );

  line_writer #(
    .fifo_lines (fifo_lines)
  ) line_writer_i (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .dst_base      (dst_base),
    .dst_lines     (dst_lines),
    .dsm_addr      (dsm_addr),
    .dec_out_data  (dec_out_data),
    .dec_out_valid (dec_out_valid),
    .wr_valid      (wr_valid),
    .wr_ready      (wr_ready),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .ack_valid     (wr_ack_valid),
    .done          (done)
  );

  mem_arbiter mem_arbiter_i (
    .clk           (clk),
    .reset         (reset),
    .rd_req_valid  (rd_valid),
    .rd_req_addr   (rd_addr),
    .rd_req_ready  (rd_ready),
    .wr_req_valid  (wr_valid),
    .wr_req_addr   (wr_addr),
    .wr_req_data   (wr_data),
    .wr_req_ready  (wr_ready),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_write (mem_rsp_write),
    .mem_rsp_data  (mem_rsp_data),
    .rd_rsp_valid  (rd_rsp_valid),
    .rd_rsp_data   (rd_rsp_data),
    .wr_ack_valid  (wr_ack_valid)
  );

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
// Round-robin arbiter of the line reader and line writer onto one memory port.
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import fec_dma_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  rd_req_valid,
  input  addr_t rd_req_addr,
  output logic  rd_req_ready,
  input  logic  wr_req_valid,
  input  addr_t wr_req_addr,
  input  line_t wr_req_data,
  output logic  wr_req_ready,
  output logic  mem_req_valid,
  input  logic  mem_req_ready,
  output logic  mem_req_write,
  output addr_t mem_req_addr,
  output line_t mem_req_data,
  input  logic  mem_rsp_valid,
  input  logic  mem_rsp_write,
  input  line_t mem_rsp_data,
  output logic  rd_rsp_valid,
  output line_t rd_rsp_data,
  output logic  wr_ack_valid
);

  localparam int order_depth = 32;
  localparam int ord_w       = $clog2(order_depth);

  mem_op_t        prio;
  mem_op_t        held;
  mem_op_t        sel;
  logic           locked;  // A request is stalled and its grant must hold.
  logic           xfer;
  mem_op_t        order_q [order_depth];
  logic [ord_w-1:0] ord_wr;
  logic [ord_w-1:0] ord_rd;
  logic [ord_w:0]   ord_cnt;

  always_comb begin
    if (locked) sel = held;
    else if (rd_req_valid && wr_req_valid) sel = prio;
    else if (wr_req_valid) sel = op_write;
    else sel = op_read;
  end

  assign mem_req_valid = (sel == op_write) ? wr_req_valid : rd_req_valid;
  assign mem_req_write = (sel == op_write);
  assign mem_req_addr  = (sel == op_write) ? wr_req_addr : rd_req_addr;
  assign mem_req_data  = (sel == op_write) ? wr_req_data : '0;
  assign rd_req_ready  = mem_req_ready && (sel == op_read);
  assign wr_req_ready  = mem_req_ready && (sel == op_write);
  assign xfer          = mem_req_valid && mem_req_ready;

  assign rd_rsp_valid = mem_rsp_valid && !mem_rsp_write;
  assign rd_rsp_data  = mem_rsp_data;
  assign wr_ack_valid = mem_rsp_valid && mem_rsp_write;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prio    <= op_read;
      held    <= op_read;
      locked  <= 1'b0;
      ord_wr  <= '0;
      ord_rd  <= '0;
      ord_cnt <= '0;
    end else begin
      locked <= mem_req_valid && !mem_req_ready;
      held   <= sel;
      if (xfer) prio <= (sel == op_write) ? op_read : op_write;
      if (xfer) ord_wr <= ord_wr + 1'b1;
      if (mem_rsp_valid) ord_rd <= ord_rd + 1'b1;
      ord_cnt <= ord_cnt + (ord_w + 1)'(xfer) - (ord_w + 1)'(mem_rsp_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) order_q[ord_wr] <= sel;
  end

  // The requestors hold a stalled request unchanged until it transfers.
  a_req_held: assert property (@(posedge clk) disable iff (reset)
    (mem_req_valid && !mem_req_ready) |=>
      (mem_req_valid && $stable(mem_req_write) && $stable(mem_req_addr) &&
       $stable(mem_req_data)));

  // Each response belongs to the oldest granted request.
  a_rsp_order: assert property (@(posedge clk) disable iff (reset)
    mem_rsp_valid |-> (ord_cnt != '0) && (mem_rsp_write == (order_q[ord_rd] == op_write)));

endmodule

`default_nettype wire

// ==== requestor/line_writer.sv ====
// Byte packer, write FIFO, destination write issue and completion flag writer.
`timescale 1ns/100ps
`default_nettype none

module line_writer import fec_dma_pkg::*; #(
  parameter int fifo_lines = 8
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  addr_t       dst_base,
  input  logic [15:0] dst_lines,
  input  addr_t       dsm_addr,
  input  logic [7:0]  dec_out_data,
  input  logic        dec_out_valid,
  output logic        wr_valid,
  input  logic        wr_ready,
  output addr_t       wr_addr,
  output line_t       wr_data,
  input  logic        ack_valid,
  output logic        done
);

  typedef enum logic [1:0] {s_idle, s_data, s_dsm, s_dsm_wait} wr_state_t;

  wr_state_t   state;
  line_t       pack_q;
  logic [2:0]  byte_cnt;
  logic        push;
  logic [15:0] line_cnt;
  logic [15:0] ack_cnt;
  wr_entry_t   enq_entry;
  wr_entry_t   head;
  logic        wq_not_full;
  logic        wq_not_empty;
  logic        xfer;

  assign xfer      = wr_valid && wr_ready;
  assign enq_entry = '{data: pack_q, offset: line_cnt};
  assign wr_valid  = (state == s_data) ? wq_not_empty : (state == s_dsm);
  assign wr_addr   = (state == s_data) ? dst_base + addr_t'(head.offset) : dsm_addr;
  assign wr_data   = (state == s_data) ? head.data : dsm_done_value;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      byte_cnt <= '0;
      push     <= 1'b0;
      line_cnt <= '0;
    end else if (start) begin
      byte_cnt <= '0;
      push     <= 1'b0;
      line_cnt <= '0;
    end else begin
      push <= dec_out_valid && (byte_cnt == 3'(bytes_per_line - 1));  // Line is complete.
      if (dec_out_valid) byte_cnt <= byte_cnt + 3'd1;
      if (push) line_cnt <= line_cnt + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_out_valid) pack_q <= {pack_q[55:0], dec_out_data};
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= s_idle;
      ack_cnt <= '0;
      done    <= 1'b0;
    end else begin
      if (start) ack_cnt <= '0;
      else if (ack_valid && (state == s_data)) ack_cnt <= ack_cnt + 16'd1;
      case (state)
        s_idle: begin
          if (start) begin
            state <= s_data;
            done  <= 1'b0;
          end
        end
        s_data: begin
          if (ack_cnt == dst_lines) state <= s_dsm;  // All destination lines are in memory.
        end
        s_dsm: begin
          if (xfer) state <= s_dsm_wait;
        end
        default: begin
          if (ack_valid) begin
            state <= s_idle;
            done  <= 1'b1;
          end
        end
      endcase
    end
  end

  line_fifo #(
    .payload_t (wr_entry_t),
    .depth     (fifo_lines)
  ) wr_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .enq_data  (enq_entry),
    .enq_en    (push),
    .deq_en    (xfer && (state == s_data)),
    .deq_data  (head),
    .not_full  (wq_not_full),
    .not_empty (wq_not_empty),
    .count     ()
  );

  // The paced byte stream and the arbiter keep the write FIFO from ever filling.
  a_wq_never_full: assert property (@(posedge clk) disable iff (reset) wq_not_full);

endmodule

`default_nettype wire

// ==== requestor/byte_serializer.sv ====
// Line to byte serializer that paces bytes to the decoder core.
`timescale 1ns/100ps
`default_nettype none

module byte_serializer import fec_dma_pkg::*; #(
  parameter int byte_gap = 3
) (
  input  logic       clk,
  input  logic       reset,
  input  line_t      line_data,
  input  logic       line_valid,
  output logic       line_pop,
  output logic [7:0] dec_in_data,
  output logic       dec_in_valid
);

  localparam int gap_w = $clog2(byte_gap + 2);

  line_t            shift_q;
  logic [3:0]       bytes_left;
  logic [gap_w-1:0] gap_cnt;
  logic             emit;

  assign line_pop = line_valid && (bytes_left == '0);  // Load as soon as the last line is out.
  assign emit     = (bytes_left != '0) && (gap_cnt == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      bytes_left   <= '0;
      gap_cnt      <= '0;
      dec_in_valid <= 1'b0;
    end else begin
      dec_in_valid <= emit;
      if (line_pop) bytes_left <= 4'(bytes_per_line);
      else if (emit) bytes_left <= bytes_left - 4'd1;
      if (emit) gap_cnt <= gap_w'(byte_gap);
      else if (gap_cnt != '0) gap_cnt <= gap_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (line_pop) begin
      shift_q <= line_data;
    end else if (emit) begin
      shift_q     <= {shift_q[55:0], 8'h00};
      dec_in_data <= shift_q[63:56];  // Most significant byte first.
    end
  end

endmodule

`default_nettype wire

// ==== requestor/line_reader.sv ====
// Line read request FSM with an outstanding-line credit count and a response FIFO.
`timescale 1ns/100ps
`default_nettype none

module line_reader import fec_dma_pkg::*; #(
  parameter int fifo_lines = 8
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  addr_t       src_base,
  input  logic [15:0] src_lines,
  output logic        rd_valid,
  input  logic        rd_ready,
  output addr_t       rd_addr,
  input  logic        rsp_valid,
  input  line_t       rsp_data,
  output line_t       line_data,
  output logic        line_valid,
  input  logic        line_pop
);

  localparam int cnt_w = $clog2(fifo_lines) + 1;

  typedef enum logic [1:0] {s_idle, s_fetch, s_wait, s_finish} rd_state_t;

  rd_state_t        state;
  logic [15:0]      offset;
  logic [cnt_w-1:0] credits;  // Lines requested and not yet popped.
  logic [cnt_w-1:0] credits_next;
  logic [cnt_w-1:0] fifo_count;
  logic             xfer;

  assign rd_valid     = (state == s_fetch);
  assign rd_addr      = src_base + addr_t'(offset);
  assign xfer         = rd_valid && rd_ready;
  assign credits_next = credits + cnt_w'(xfer) - cnt_w'(line_pop);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= s_idle;
      offset  <= '0;
      credits <= '0;
    end else begin
      credits <= credits_next;
      case (state)
        s_idle: begin
          if (start) begin
            offset <= '0;
            state  <= (src_lines == '0) ? s_finish : s_fetch;
          end
        end
        s_fetch: begin
          if (xfer) begin
            offset <= offset + 16'd1;
            if (offset + 16'd1 == src_lines) state <= s_finish;
            else if (credits_next == cnt_w'(fifo_lines)) state <= s_wait;
          end
        end
        s_wait: begin
          if (credits < cnt_w'(fifo_lines)) state <= s_fetch;  // A line was consumed.
        end
        default: begin
          if (credits == '0) state <= s_idle;  // Every fetched line has been consumed.
        end
      endcase
    end
  end

  line_fifo #(
    .payload_t (line_t),
    .depth     (fifo_lines)
  ) line_fifo_i (
    .clk       (clk),
    .reset     (reset),
    .enq_data  (rsp_data),
    .enq_en    (rsp_valid),
    .deq_en    (line_pop),
    .deq_data  (line_data),
    .not_full  (),
    .not_empty (line_valid),
    .count     (fifo_count)
  );

  // Responses routed back by the arbiter can never outrun the issued credits.
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    fifo_count <= credits);

endmodule

`default_nettype wire

// ==== requestor/line_fifo.sv ====
// Synchronous show-ahead FIFO with a type-parameter payload and a fill count.
`timescale 1ns/100ps
`default_nettype none

module line_fifo #(
  parameter type payload_t = logic [63:0],
  parameter int  depth     = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  payload_t               enq_data,
  input  logic                   enq_en,
  input  logic                   deq_en,
  output payload_t               deq_data,
  output logic                   not_full,
  output logic                   not_empty,
  output logic [$clog2(depth):0] count
);

  localparam int ptr_w = $clog2(depth);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  assign deq_data  = mem[rd_ptr];
  assign not_full  = (count != (ptr_w + 1)'(depth));
  assign not_empty = (count != '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_en) wr_ptr <= wr_ptr + 1'b1;  // Wraps since depth is a power of two.
      if (deq_en) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (ptr_w + 1)'(enq_en) - (ptr_w + 1)'(deq_en);
    end
  end

  always_ff @(posedge clk) begin
    if (enq_en) mem[wr_ptr] <= enq_data;
  end

  a_no_overflow:  assert property (@(posedge clk) disable iff (reset) enq_en |-> not_full);
  a_no_underflow: assert property (@(posedge clk) disable iff (reset) deq_en |-> not_empty);

endmodule

`default_nettype wire

// ==== hw/csr_apb.sv ====
// APB register file with the job descriptor, the start pulse and the done status.
`timescale 1ns/100ps
`default_nettype none

module csr_apb import fec_dma_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        start,
  output addr_t       src_base,
  output logic [15:0] src_lines,
  output addr_t       dst_base,
  output logic [15:0] dst_lines,
  output addr_t       dsm_addr,
  input  logic        done
);

  logic wr_access;

  assign pready    = 1'b1;  // No wait states.
  assign wr_access = psel && penable && pwrite;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start     <= 1'b0;
      src_base  <= '0;
      src_lines <= '0;
      dst_base  <= '0;
      dst_lines <= '0;
      dsm_addr  <= '0;
    end else begin
      start <= wr_access && (paddr == reg_ctrl) && pwdata[0];  // Self-clearing.
      if (wr_access) begin
        case (paddr)
          reg_src_base:  src_base  <= pwdata;
          reg_src_lines: src_lines <= pwdata[15:0];
          reg_dst_base:  dst_base  <= pwdata;
          reg_dst_lines: dst_lines <= pwdata[15:0];
          reg_dsm_addr:  dsm_addr  <= pwdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (paddr)
      reg_status:    prdata = {31'b0, done};
      reg_src_base:  prdata = src_base;
      reg_src_lines: prdata = {16'b0, src_lines};
      reg_dst_base:  prdata = dst_base;
      reg_dst_lines: prdata = {16'b0, dst_lines};
      reg_dsm_addr:  prdata = dsm_addr;
      default:       prdata = '0;
    endcase
  end

  // Every access phase must follow a setup phase of the same transfer.
  a_apb_setup: assert property (@(posedge clk) disable iff (reset)
    (psel && penable) |-> $past(psel && !penable));

endmodule

`default_nettype wire

// ==== common/fec_dma_pkg.sv ====
// Line and address types, register offsets, memory operation and write entry types.
`default_nettype none

package fec_dma_pkg;

  typedef logic [63:0] line_t;  // Byte 0 is the most significant byte.
  typedef logic [31:0] addr_t;  // Line address, not byte address.

  localparam int bytes_per_line = 8;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_t;

  typedef struct packed {
    line_t       data;
    logic [15:0] offset;  // Line offset from the destination base.
  } wr_entry_t;

  // APB word addresses.
  localparam logic [7:0] reg_ctrl      = 8'h00;
  localparam logic [7:0] reg_status    = 8'h01;
  localparam logic [7:0] reg_src_base  = 8'h02;
  localparam logic [7:0] reg_src_lines = 8'h03;
  localparam logic [7:0] reg_dst_base  = 8'h04;
  localparam logic [7:0] reg_dst_lines = 8'h05;
  localparam logic [7:0] reg_dsm_addr  = 8'h06;

  localparam line_t dsm_done_value = 64'd1;

endpackage

`default_nettype wire
